// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: common/cpu_pkg.sv
package cpu_pkg;

    localparam int data_width = 8;
    localparam int addr_width = 16;
    localparam int reg_index_width = 3;

    // Index 6 is the (HL) operand in the opcode and is not a register
    localparam logic [reg_index_width-1:0] reg_b = 3'd0;
    localparam logic [reg_index_width-1:0] reg_c = 3'd1;
    localparam logic [reg_index_width-1:0] reg_d = 3'd2;
    localparam logic [reg_index_width-1:0] reg_e = 3'd3;
    localparam logic [reg_index_width-1:0] reg_h = 3'd4;
    localparam logic [reg_index_width-1:0] reg_l = 3'd5;
    localparam logic [reg_index_width-1:0] reg_a = 3'd7;

    // Same encoding as opcode bits 5:3
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_adc = 3'd1;
    localparam logic [2:0] alu_sub = 3'd2;
    localparam logic [2:0] alu_sbc = 3'd3;
    localparam logic [2:0] alu_and = 3'd4;
    localparam logic [2:0] alu_xor = 3'd5;
    localparam logic [2:0] alu_or  = 3'd6;
    localparam logic [2:0] alu_cp  = 3'd7;

    localparam int flag_z_bit = 3;
    localparam int flag_n_bit = 2;
    localparam int flag_h_bit = 1;
    localparam int flag_c_bit = 0;

    localparam logic [1:0] cond_nz = 2'd0;
    localparam logic [1:0] cond_z  = 2'd1;
    localparam logic [1:0] cond_nc = 2'd2;
    localparam logic [1:0] cond_c  = 2'd3;

    localparam logic [data_width-1:0] op_jp   = 8'hC3;
    localparam logic [data_width-1:0] op_halt = 8'h76;

    typedef union packed {
        struct packed {
            logic [1:0] group;
            logic [2:0] dst;
            logic [2:0] src;
        } reg_view;
        struct packed {
            logic [2:0] prefix;   // 110 for JP cc,nn
            logic [1:0] cond;
            logic [2:0] low;      // 010 for JP cc,nn
        } cond_view;
    } opcode_t;

endpackage

// File: cpu_core.f
common/cpu_pkg.sv
execute/alu.sv
source/fetch_stage.sv
source/decode_stage.sv
execute/execute_stage.sv
source/writeback_stage.sv
source/cpu_core.sv
testbench/tb_clock.sv
testbench/cpu_core_tb.sv

// File: execute/alu.sv
module alu (
    input  logic [cpu_pkg::data_width-1:0] operand_a,
    input  logic [cpu_pkg::data_width-1:0] operand_b,
    input  logic [2:0]                     alu_op,
    input  logic                           carry_in,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic [3:0]                     flags_out
);
    import cpu_pkg::*;

    logic carry;
    logic [data_width:0] add_full;
    logic [data_width:0] sub_full;
    logic [4:0] add_half;
    logic [4:0] sub_half;
    logic [data_width-1:0] value;

    assign carry = carry_in && (alu_op == alu_adc || alu_op == alu_sbc);

    // Top bit is the carry, or the borrow on subtraction
    assign add_full = {1'b0, operand_a} + {1'b0, operand_b} + (data_width + 1)'(carry);
    assign sub_full = {1'b0, operand_a} - {1'b0, operand_b} - (data_width + 1)'(carry);
    assign add_half = {1'b0, operand_a[3:0]} + {1'b0, operand_b[3:0]} + 5'(carry);
    assign sub_half = {1'b0, operand_a[3:0]} - {1'b0, operand_b[3:0]} - 5'(carry);

    always_comb
    begin
        flags_out = '0;
        case (alu_op)
            alu_add, alu_adc:
            begin
                value = add_full[data_width-1:0];
                flags_out[flag_h_bit] = add_half[4];
                flags_out[flag_c_bit] = add_full[data_width];
            end
            alu_sub, alu_sbc, alu_cp:
            begin
                value = sub_full[data_width-1:0];
                flags_out[flag_n_bit] = 1'b1;
                flags_out[flag_h_bit] = sub_half[4];
                flags_out[flag_c_bit] = sub_full[data_width];
            end
            alu_and:
            begin
                value = operand_a & operand_b;
                flags_out[flag_h_bit] = 1'b1;
            end
            alu_xor: value = operand_a ^ operand_b;
            alu_or:  value = operand_a | operand_b;
        endcase
        flags_out[flag_z_bit] = (value == '0);
        result = (alu_op == alu_cp) ? operand_a : value; // CP only sets flags
    end

endmodule

// File: execute/execute_stage.sv
module execute_stage (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 issue_valid,
    input  logic [2:0]                           issue_alu_op,
    input  logic                                 issue_use_alu,
    input  logic [cpu_pkg::data_width-1:0]       issue_operand_a,
    input  logic [cpu_pkg::data_width-1:0]       issue_operand_b,
    input  logic                                 issue_write_reg,
    input  logic [cpu_pkg::reg_index_width-1:0] issue_dest,
    input  logic                                 issue_store,
    input  logic [cpu_pkg::addr_width-1:0]       issue_store_address,
    input  logic                                 issue_jump,
    input  logic                                 issue_conditional,
    input  logic [1:0]                           issue_cond,
    input  logic [cpu_pkg::addr_width-1:0]       issue_target,
    output logic                                 wb_valid,
    output logic                                 wb_write_reg,
    output logic [cpu_pkg::reg_index_width-1:0] wb_dest,
    output logic [cpu_pkg::data_width-1:0]       wb_result,
    output logic                                 wb_store,
    output logic [cpu_pkg::addr_width-1:0]       wb_store_address,
    output logic                                 redirect,
    output logic [cpu_pkg::addr_width-1:0]       redirect_address
);
    import cpu_pkg::*;

    localparam logic [3:0] flags_reset = 4'(1 << flag_z_bit);

    logic [3:0] flags;
    logic [3:0] alu_flags;
    logic [data_width-1:0] alu_result;
    logic cond_true;

    alu alu_unit (
        .operand_a(issue_operand_a),
        .operand_b(issue_operand_b),
        .alu_op(issue_alu_op),
        .carry_in(flags[flag_c_bit]),
        .result(alu_result),
        .flags_out(alu_flags)
    );

    always_comb
    begin
        case (issue_cond)
            cond_nz: cond_true = !flags[flag_z_bit];
            cond_z:  cond_true = flags[flag_z_bit];
            cond_nc: cond_true = !flags[flag_c_bit];
            cond_c:  cond_true = flags[flag_c_bit];
        endcase
    end

    assign redirect = issue_valid && issue_jump && (!issue_conditional || cond_true);
    assign redirect_address = issue_target;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flags <= flags_reset;
            wb_valid <= 1'b0;
            wb_write_reg <= 1'b0;
            wb_store <= 1'b0;
        end
        else
        begin
            wb_valid <= issue_valid;
            wb_write_reg <= issue_write_reg && !(issue_use_alu && issue_alu_op == alu_cp);
            wb_store <= issue_store;
            if (issue_valid && issue_use_alu)
                flags <= alu_flags;
        end
    end

    always_ff @(posedge clock)
    begin
        wb_dest <= issue_dest;
        wb_result <= issue_use_alu ? alu_result : issue_operand_b; // Load value or store data
        wb_store_address <= issue_store_address;
    end

    // Decode drops whatever sits behind a taken jump
    assert property (@(posedge clock) disable iff (!rst_n)
        redirect |=> !issue_valid && !redirect)
        else $error("item executed behind a taken jump");

endmodule

// File: source/cpu_core.sv
module cpu_core #(
    parameter logic [cpu_pkg::addr_width-1:0] reset_address = '0
) (
    input  logic                           clock,
    input  logic                           rst_n,
    output logic [cpu_pkg::addr_width-1:0] mem_address,
    input  logic [cpu_pkg::data_width-1:0] mem_read_data,
    output logic [cpu_pkg::data_width-1:0] mem_write_data,
    output logic                           mem_nread,
    output logic                           mem_nwrite
);
    import cpu_pkg::*;

    logic fetch_valid;
    logic [data_width-1:0] fetch_opcode;
    logic [data_width-1:0] fetch_imm_low;
    logic [data_width-1:0] fetch_imm_high;
    logic [addr_width-1:0] fetch_address;
    logic fetch_read;
    logic decode_stall;
    logic bus_busy;
    logic redirect;
    logic [addr_width-1:0] redirect_address;

    logic issue_valid;
    logic [2:0] issue_alu_op;
    logic issue_use_alu;
    logic [data_width-1:0] issue_operand_a;
    logic [data_width-1:0] issue_operand_b;
    logic issue_write_reg;
    logic [reg_index_width-1:0] issue_dest;
    logic issue_store;
    logic [addr_width-1:0] issue_store_address;
    logic issue_jump;
    logic issue_conditional;
    logic [1:0] issue_cond;
    logic [addr_width-1:0] issue_target;

    logic wb_valid;
    logic wb_write_reg;
    logic [reg_index_width-1:0] wb_dest;
    logic [data_width-1:0] wb_result;
    logic wb_store;
    logic [addr_width-1:0] wb_store_address;

    // Register file write port
    logic reg_write;
    logic [reg_index_width-1:0] reg_write_index;
    logic [data_width-1:0] reg_write_data;

    fetch_stage #(.reset_address(reset_address)) fetch (.*);

    decode_stage decode (.*);

    execute_stage execute (.*);

    writeback_stage writeback (.*);

endmodule

// File: source/decode_stage.sv
module decode_stage (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 fetch_valid,
    input  logic [cpu_pkg::data_width-1:0]       fetch_opcode,
    input  logic [cpu_pkg::data_width-1:0]       fetch_imm_low,
    input  logic [cpu_pkg::data_width-1:0]       fetch_imm_high,
    input  logic                                 redirect,
    input  logic                                 reg_write,
    input  logic [cpu_pkg::reg_index_width-1:0] reg_write_index,
    input  logic [cpu_pkg::data_width-1:0]       reg_write_data,
    input  logic                                 wb_valid,
    input  logic                                 wb_write_reg,
    input  logic [cpu_pkg::reg_index_width-1:0] wb_dest,
    output logic                                 decode_stall,
    output logic                                 issue_valid,
    output logic [2:0]                           issue_alu_op,
    output logic                                 issue_use_alu,
    output logic [cpu_pkg::data_width-1:0]       issue_operand_a,
    output logic [cpu_pkg::data_width-1:0]       issue_operand_b,
    output logic                                 issue_write_reg,
    output logic [cpu_pkg::reg_index_width-1:0] issue_dest,
    output logic                                 issue_store,
    output logic [cpu_pkg::addr_width-1:0]       issue_store_address,
    output logic                                 issue_jump,
    output logic                                 issue_conditional,
    output logic [1:0]                           issue_cond,
    output logic [cpu_pkg::addr_width-1:0]       issue_target
);
    import cpu_pkg::*;

    localparam logic [reg_index_width-1:0] mem_index = 3'd6;

    logic [data_width-1:0] regs [8];
    opcode_t op;
    logic src_is_mem;
    logic dst_is_mem;
    logic ld_imm;
    logic ld_reg;
    logic is_store;
    logic alu_reg;
    logic alu_imm;
    logic jp_cc;
    logic read_src;
    logic read_a;
    logic read_hl;

    assign op = fetch_opcode;
    assign src_is_mem = op.reg_view.src == mem_index;
    assign dst_is_mem = op.reg_view.dst == mem_index;
    assign ld_imm = op.reg_view.group == 2'b00 && src_is_mem && !dst_is_mem;
    assign ld_reg = op.reg_view.group == 2'b01 && !src_is_mem && !dst_is_mem;
    assign is_store = op.reg_view.group == 2'b01 && !src_is_mem && dst_is_mem;
    assign alu_reg = op.reg_view.group == 2'b10 && !src_is_mem;
    assign alu_imm = op.reg_view.group == 2'b11 && src_is_mem;
    assign jp_cc = op.cond_view.prefix == 3'b110 && op.cond_view.low == 3'b010;

    assign read_src = ld_reg || is_store || alu_reg;
    assign read_a = alu_reg || alu_imm;
    assign read_hl = is_store;  // Store address

    function automatic logic reads_reg(input logic [reg_index_width-1:0] index);
        return (read_src && index == op.reg_view.src) || (read_a && index == reg_a)
            || (read_hl && (index == reg_h || index == reg_l));
    endfunction

    // Hold the item until older writers to its operands have retired
    assign decode_stall = fetch_valid
        && ((issue_valid && issue_write_reg && reads_reg(issue_dest))
        || (wb_valid && wb_write_reg && reads_reg(wb_dest)));

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            issue_valid <= 1'b0;
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else
        begin
            issue_valid <= fetch_valid && !decode_stall && !redirect;
            if (reg_write)
                regs[reg_write_index] <= reg_write_data;
        end
    end

    always_ff @(posedge clock)
    begin
        issue_alu_op <= op.reg_view.dst;
        issue_use_alu <= alu_reg || alu_imm;
        issue_operand_a <= regs[reg_a];
        issue_operand_b <= (ld_imm || alu_imm) ? fetch_imm_low : regs[op.reg_view.src];
        issue_write_reg <= ld_imm || ld_reg || alu_reg || alu_imm;
        issue_dest <= (alu_reg || alu_imm) ? reg_a : op.reg_view.dst;
        issue_store <= is_store;
        issue_store_address <= {regs[reg_h], regs[reg_l]};
        issue_jump <= fetch_opcode == op_jp || jp_cc;
        issue_conditional <= jp_cc;
        issue_cond <= op.cond_view.cond;
        issue_target <= {fetch_imm_high, fetch_imm_low};
    end

    // Slot 6 is the memory operand, never a register
    assert property (@(posedge clock) disable iff (!rst_n)
        reg_write |-> reg_write_index != mem_index)
        else $error("register write to the memory operand slot");

endmodule

// File: source/fetch_stage.sv
module fetch_stage #(
    parameter logic [cpu_pkg::addr_width-1:0] reset_address = '0
) (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic [cpu_pkg::data_width-1:0]  mem_read_data,
    input  logic                            bus_busy,
    input  logic                            decode_stall,
    input  logic                            redirect,
    input  logic [cpu_pkg::addr_width-1:0]  redirect_address,
    output logic [cpu_pkg::addr_width-1:0]  fetch_address,
    output logic                            fetch_read,
    output logic                            fetch_valid,
    output logic [cpu_pkg::data_width-1:0]  fetch_opcode,
    output logic [cpu_pkg::data_width-1:0]  fetch_imm_low,
    output logic [cpu_pkg::data_width-1:0]  fetch_imm_high
);
    import cpu_pkg::*;

    logic [addr_width-1:0] pc;
    logic [1:0] byte_count;
    logic [1:0] length;
    logic item_valid;
    logic halted;
    logic take_byte;
    logic last_byte;

    // Jumps carry an address, LD r,n and ALU A,n one immediate
    function automatic logic [1:0] inst_length(input logic [data_width-1:0] op);
        if (op == op_jp || (op[7:5] == 3'b110 && op[2:0] == 3'b010))
            return 2'd3;
        if (op[2:0] == 3'b110 && (op[7:6] == 2'b00 || op[7:6] == 2'b11))
            return 2'd2;
        return 2'd1;
    endfunction

    assign length = inst_length((byte_count == 2'd0) ? mem_read_data : fetch_opcode);
    assign last_byte = (byte_count == length - 2'd1);
    assign fetch_read = !halted && !(item_valid && decode_stall);
    assign take_byte = fetch_read && !bus_busy;
    assign fetch_address = pc;
    assign fetch_valid = item_valid && !redirect; // Item behind a taken jump

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= reset_address;
            byte_count <= 2'd0;
            item_valid <= 1'b0;
            halted <= 1'b0;
        end
        else if (redirect)
        begin
            pc <= redirect_address;
            byte_count <= 2'd0;
            item_valid <= 1'b0;
            halted <= 1'b0;  // HALT fetched past the jump
        end
        else
        begin
            if (item_valid && !decode_stall)
                item_valid <= 1'b0;
            if (take_byte)
            begin
                pc <= pc + 1'b1;
                byte_count <= last_byte ? 2'd0 : byte_count + 2'd1;
                if (last_byte)
                    item_valid <= 1'b1;
                if (byte_count == 2'd0 && mem_read_data == op_halt)
                    halted <= 1'b1;
            end
        end
    end

    // Bytes land straight in the output item, the old one is gone by then
    always_ff @(posedge clock)
    begin
        if (take_byte && !redirect)
        begin
            case (byte_count)
                2'd0:    fetch_opcode <= mem_read_data;
                2'd1:    fetch_imm_low <= mem_read_data;
                default: fetch_imm_high <= mem_read_data;
            endcase
        end
    end

    // Nothing offered in the cycle after a redirect
    assert property (@(posedge clock) disable iff (!rst_n)
        redirect |=> !fetch_valid)
        else $error("fetch item offered across a redirect");

endmodule

// File: source/writeback_stage.sv
module writeback_stage (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 wb_valid,
    input  logic                                 wb_write_reg,
    input  logic [cpu_pkg::reg_index_width-1:0] wb_dest,
    input  logic [cpu_pkg::data_width-1:0]       wb_result,
    input  logic                                 wb_store,
    input  logic [cpu_pkg::addr_width-1:0]       wb_store_address,
    input  logic [cpu_pkg::addr_width-1:0]       fetch_address,
    input  logic                                 fetch_read,
    output logic                                 reg_write,
    output logic [cpu_pkg::reg_index_width-1:0] reg_write_index,
    output logic [cpu_pkg::data_width-1:0]       reg_write_data,
    output logic                                 bus_busy,
    output logic [cpu_pkg::addr_width-1:0]       mem_address,
    output logic [cpu_pkg::data_width-1:0]       mem_write_data,
    output logic                                 mem_nread,
    output logic                                 mem_nwrite
);
    import cpu_pkg::*;

    logic store_active;
    logic [addr_width-1:0] store_address;

    assign reg_write = wb_valid && wb_write_reg;
    assign reg_write_index = wb_dest;
    assign reg_write_data = wb_result;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            store_active <= 1'b0;
        else
            store_active <= wb_valid && wb_store;
    end

    always_ff @(posedge clock)
    begin
        if (wb_valid && wb_store)
        begin
            store_address <= wb_store_address;
            mem_write_data <= wb_result;
        end
    end

    // Store wins the bus, fetch waits a cycle
    assign bus_busy = store_active;
    assign mem_nwrite = !store_active;
    assign mem_nread = !(fetch_read && !store_active);
    assign mem_address = store_active ? store_address : fetch_address;

    assert property (@(posedge clock) disable iff (!rst_n)
        (wb_valid && wb_store) |=> mem_address == $past(wb_store_address)
        && mem_write_data == $past(wb_result))
        else $error("store cycle lost its address or data");

endmodule

// File: testbench/cpu_core_tb.sv
module cpu_core_tb;
    import cpu_pkg::*;

    localparam logic [addr_width-1:0] start_address = 16'h0100;
    localparam int max_stores = 256;

    logic clock;
    logic rst_n;
    logic [addr_width-1:0] mem_address;
    logic [data_width-1:0] mem_read_data;
    logic [data_width-1:0] mem_write_data;
    logic mem_nread;
    logic mem_nwrite;
    logic [data_width-1:0] memory [65536];
    logic [data_width-1:0] model_regs [8];
    logic [3:0] model_flags;
    logic [addr_width-1:0] expected_address [max_stores];
    logic [data_width-1:0] expected_data [max_stores];
    logic [addr_width-1:0] build_pc;
    logic [addr_width-1:0] halt_address;
    logic halt_seen = 1'b0;
    int expected_count = 0;
    int store_count = 0;
    int cycle_count = 0;
    int timeout_limit = 0;
    integer seed = 70;

    tb_clock #(.period(10), .reset_cycles(2)) clock_gen (.clock(clock), .rst_n(rst_n));

    cpu_core #(.reset_address(start_address)) uut (.*);

    assign mem_read_data = memory[mem_address];

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
    endtask

    task automatic put_byte(input logic [7:0] value);
        memory[build_pc] = value;
        build_pc = build_pc + 16'd1;
    endtask

    task automatic load(input logic [2:0] dst, input logic [7:0] value);
        put_byte({2'b00, dst, 3'b110});
        put_byte(value);
        model_regs[dst] = value;
    endtask

    task automatic copy(input logic [2:0] dst, input logic [2:0] src);
        put_byte({2'b01, dst, src});
        model_regs[dst] = model_regs[src];
    endtask

    task automatic store(input logic [2:0] src);
        put_byte({2'b01, 3'b110, src});
        expected_address[expected_count] = {model_regs[reg_h], model_regs[reg_l]};
        expected_data[expected_count] = model_regs[src];
        expected_count++;
    endtask

    // Operand is an immediate byte or a register index
    task automatic alu_step(input logic [2:0] op, input logic immediate, input logic [7:0] value);
        int a;
        int b;
        int c;
        int r;
        if (immediate)
        begin
            put_byte({2'b11, op, 3'b110});
            put_byte(value);
            b = value;
        end
        else
        begin
            put_byte({2'b10, op, value[2:0]});
            b = model_regs[value[2:0]];
        end
        a = model_regs[reg_a];
        c = (op == alu_adc || op == alu_sbc) ? model_flags[flag_c_bit] : 0;
        model_flags = '0;
        case (op)
            alu_add, alu_adc:
            begin
                r = a + b + c;
                model_flags[flag_h_bit] = (a % 16 + b % 16 + c) > 15;
                model_flags[flag_c_bit] = r > 255;
            end
            alu_sub, alu_sbc, alu_cp:
            begin
                r = a - b - c;
                model_flags[flag_n_bit] = 1'b1;
                model_flags[flag_h_bit] = (a % 16) < (b % 16 + c);  // Borrow from bit 4
                model_flags[flag_c_bit] = r < 0;
            end
            alu_and:
            begin
                r = a & b;
                model_flags[flag_h_bit] = 1'b1;
            end
            alu_xor: r = a ^ b;
            default: r = a | b;
        endcase
        model_flags[flag_z_bit] = 8'(r) == 8'd0;
        if (op != alu_cp)
            model_regs[reg_a] = 8'(r);
    endtask

    // The store right behind the jump only runs when it falls through
    task automatic branch(input logic conditional, input logic [1:0] cc);
        logic taken;
        logic [addr_width-1:0] target;
        case (cc)
            cond_nz: taken = !model_flags[flag_z_bit];
            cond_z:  taken = model_flags[flag_z_bit];
            cond_nc: taken = !model_flags[flag_c_bit];
            default: taken = model_flags[flag_c_bit];
        endcase
        target = build_pc + 16'd4;
        put_byte(conditional ? {3'b110, cc, 3'b010} : op_jp);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
        if (taken || !conditional)
            put_byte({2'b01, 3'b110, reg_a});
        else
            store(reg_a);
    endtask

    task automatic build_program();
        logic [2:0] pick;
        build_pc = start_address;
        for (int i = 0; i < 8; i++)
            model_regs[i] = '0;
        model_flags = '0;
        model_flags[flag_z_bit] = 1'b1;
        load(reg_h, 8'h90);  // Data page, well clear of the code
        load(reg_l, 8'h00);
        load(reg_b, 8'h12);
        store(reg_b);
        copy(reg_c, reg_b);
        store(reg_c);
        load(reg_l, 8'h01);
        store(reg_c);
        load(reg_d, 8'h34);
        copy(reg_e, reg_d);
        copy(reg_a, reg_e);
        load(reg_l, 8'h02);
        store(reg_a);
        store(reg_h);
        store(reg_l);
        load(reg_a, 8'hF0);
        load(reg_b, 8'h20);
        alu_step(alu_add, 1'b0, reg_b);  // Carry out into ADC
        alu_step(alu_adc, 1'b1, 8'h01);
        store(reg_a);
        alu_step(alu_sub, 1'b1, 8'h20);  // Borrow into SBC
        alu_step(alu_sbc, 1'b0, reg_b);
        store(reg_a);
        for (int op = 0; op < 8; op++)
        begin
            load(reg_d, 8'(op * 55 + 41));
            alu_step(3'(op), 1'b0, reg_d);
            store(reg_a);
            alu_step(3'(op), 1'b1, 8'(op * 91 + 196));
            store(reg_a);
        end
        branch(1'b0, cond_nz);
        load(reg_a, 8'h00);
        alu_step(alu_or, 1'b1, 8'h00);  // Z set, C clear
        for (int cc = 0; cc < 4; cc++)
            branch(1'b1, 2'(cc));
        load(reg_a, 8'hF0);
        alu_step(alu_add, 1'b1, 8'h20);  // Z clear, C set
        for (int cc = 0; cc < 4; cc++)
            branch(1'b1, 2'(cc));
        for (int i = 0; i < 40; i++)
        begin
            pick = 3'($unsigned($random(seed)) % 7);
            if (pick == 3'd6)
                pick = reg_a;
            case ($unsigned($random(seed)) % 4)
                0: alu_step(3'($random(seed)), 1'b0, pick);
                1: alu_step(3'($random(seed)), 1'b1, 8'($random(seed)));
                2: load((pick == reg_h) ? reg_l : pick, 8'($random(seed)));  // H stays put
                default: store(pick);
            endcase
        end
        store(reg_a);
        halt_address = build_pc;
        put_byte(op_halt);
    endtask

    always @(negedge clock)
        if (rst_n && !mem_nwrite)
            memory[mem_address] = mem_write_data;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (rst_n && !mem_nwrite)
            store_count <= store_count + 1;
        if (rst_n && !mem_nread && mem_address == halt_address)
            halt_seen <= 1'b1;
        if (cycle_count > timeout_limit)
        begin
            report_failure($sformatf("timeout: program unfinished after %0d cycles", cycle_count));
            $fatal(1);
        end
    end

    assert property (@(negedge clock) !rst_n |-> mem_nwrite)
    else
    begin
        report_failure("write strobe went low during reset");
        $fatal(1);
    end

    assert property (@(posedge clock) $rose(rst_n)
        |-> !mem_nread && mem_nwrite && mem_address == start_address)
    else
    begin
        report_failure($sformatf("mismatch at time %0t: first bus cycle at %h, expected read at %h",
            $time, $sampled(mem_address), start_address));
        $fatal(1);
    end

    assert property (@(negedge clock) disable iff (!rst_n)
        !mem_nwrite |-> store_count < expected_count)
    else
    begin
        report_failure($sformatf("unexpected extra store to %h at time %0t", mem_address, $time));
        $fatal(1);
    end

    assert property (@(negedge clock) disable iff (!rst_n)
        !mem_nwrite && store_count < expected_count
        |-> mem_address == expected_address[store_count]
        && mem_write_data == expected_data[store_count])
    else
    begin
        report_failure($sformatf("mismatch at time %0t: store %0d wrote %h to %h, expected %h to %h",
            $time, store_count, mem_write_data, mem_address,
            expected_data[store_count], expected_address[store_count]));
        $fatal(1);
    end

    assert property (@(negedge clock) disable iff (!rst_n) halt_seen |-> mem_nread)
    else
    begin
        report_failure($sformatf("bus read at %h after HALT was fetched", mem_address));
        $fatal(1);
    end

    initial
    begin
        for (int i = 0; i < 65536; i++)
            memory[i] = 8'(i ^ (i >> 8));
        build_program();
        timeout_limit = 8 * int'(build_pc - start_address) + 200;
        while (!(halt_seen && store_count == expected_count))
            @(negedge clock);
        repeat (20) @(negedge clock);  // Bus must stay quiet
        if (store_count == expected_count)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
        begin
            report_failure("stores appeared after the program ended");
            $fatal(1);
        end
    end

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
    parameter int period = 10,
    parameter int reset_cycles = 2
) (
    output logic clock,
    output logic rst_n
);

    initial
    begin
        clock = 1'b0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        rst_n = 1'b1;  // Released on a falling edge
    end

    always #(period / 2) clock = ~clock;

endmodule
